/* flist.f */
verilog/sync_time_pkg.sv
verilog/sync_ctrl_pkg.sv
verilog/addsub_pipe.sv
verilog/sync_time_aligner.sv
verilog/next_sync_predictor.sv
verilog/sys_time_tracker.sv
verilog/sys_time_sync.sv
test/sys_time_sync_assert.sv
test/sys_time_sync_tb.sv

/* test/sys_time_sync_tb.sv */
// ECAT_SYNC is driven in step with CLK so synchronizer jitter is not exercised, needs the bound checker
`timescale 1ns/1ps
`default_nettype none

module sys_time_sync_tb;

  localparam int period_cycles = 10240;       // sync period in ticks
  localparam logic [63:0] period_ns = 64'd500000;
  localparam int slew_d = 5;                  // edge offset for the early and late tests
  localparam longint watchdog_ns = (6 * period_cycles + 2000) * 40;

  logic                              CLK;
  logic                              reset;
  logic [sync_time_pkg::time_w-1:0]  ECAT_SYNC_TIME;
  logic                              SET;
  logic                              ECAT_SYNC;
  logic [sync_time_pkg::time_w-1:0]  SYS_TIME;
  logic                              SYNC;
  logic                              SKIP_ONE_ASSERT;

  logic [31:0]                       lfsr_state;
  logic [63:0]                       cycle_count = '0;
  logic [63:0]                       sync_cycle;  // cycle_count at the negedge that showed SYNC
  logic [sync_time_pkg::time_w-1:0]  ref_time;    // SYS_TIME expected one cycle after that SYNC

  sys_time_sync sys_time_sync_i (
    .CLK             (CLK),
    .reset           (reset),
    .ECAT_SYNC_TIME  (ECAT_SYNC_TIME),
    .SET             (SET),
    .ECAT_SYNC       (ECAT_SYNC),
    .SYS_TIME        (SYS_TIME),
    .SYNC            (SYNC),
    .SKIP_ONE_ASSERT (SKIP_ONE_ASSERT)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 64'd1;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic compare_time(input string name,
                              input logic [sync_time_pkg::time_w-1:0] expected,
                              input logic [sync_time_pkg::time_w-1:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s expected %0d got %0d",
                         $time, name, expected, actual));
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s expected %b got %b",
                         $time, name, expected, actual));
    end
  endtask

  task automatic compare_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s expected %0d got %0d",
                         $time, name, expected, actual));
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // one LFSR step per bit of the drawn time
  task automatic draw_time(output logic [63:0] t);
    t = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      t = {t[62:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [63:0] aligned_ticks(input logic [63:0] t_ns);
    return (t_ns / period_ns) * 64'(period_cycles);
  endfunction

  task automatic set_time(input logic [63:0] t);
    ECAT_SYNC_TIME = t;
    SET = 1'b1;
    @(negedge CLK);
    SET = 1'b0;
  endtask

  // free counting since the last sync, no slewing and no new sync
  task automatic check_counting(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge CLK);
      compare_time("SYS_TIME", ref_time + (cycle_count - sync_cycle - 64'd1), SYS_TIME);
      compare_bit("SKIP_ONE_ASSERT", 1'b0, SKIP_ONE_ASSERT);
      compare_bit("SYNC", 1'b0, SYNC);
    end
  endtask

  // returns one cycle after SYNC with ECAT_SYNC low again after three high cycles
  task automatic raise_sync;
    int waited;
    waited = 0;
    ECAT_SYNC = 1'b1;
    while (SYNC !== 1'b1) begin
      @(negedge CLK);
      waited++;
      if (waited > 8) begin
        fail_run("SYNC did not follow the rising edge of ECAT_SYNC");
      end
    end
    sync_cycle = cycle_count;
    @(negedge CLK);
    ECAT_SYNC = 1'b0;
  endtask

  task automatic wait_for_slot(input int interval);
    logic [63:0] target;
    target = sync_cycle + interval - 2;  // SYNC shows two cycles after the input rises
    if (cycle_count > target) begin
      fail_run("the next sync edge could not be placed, the test ran past its slot");
    end
    check_counting(int'(target - cycle_count));
  endtask

  task automatic sync_window(input int interval, output int skips);
    wait_for_slot(interval);
    raise_sync;
    ref_time = ref_time + 64'(period_cycles);
    skips = 0;
    repeat (100) begin
      @(negedge CLK);
      if (SKIP_ONE_ASSERT === 1'b1) begin
        skips++;
      end
    end
    compare_time("SYS_TIME", ref_time + 64'd100, SYS_TIME);
  endtask

  task automatic count_after_reset;
    compare_time("SYS_TIME", '0, SYS_TIME);
    compare_bit("SYNC", 1'b0, SYNC);
    compare_bit("SKIP_ONE_ASSERT", 1'b0, SKIP_ONE_ASSERT);
    ref_time = '0;
    sync_cycle = cycle_count - 64'd1;  // counting from reset looks like a sync just passed
    check_counting(50);
  endtask

  task automatic load_random_times;
    logic [63:0] t;
    for (int n = 0; n < 3; n++) begin
      draw_time(t);
      if (n == 1) begin
        t = t % period_ns;  // below one period, so the load gives zero
      end
      set_time(t);
      check_counting(100);
      raise_sync;
      ref_time = aligned_ticks(t);
      compare_time("SYS_TIME", ref_time, SYS_TIME);
      check_counting(50);
    end
  endtask

  task automatic nominal_period;
    int skips;
    sync_window(period_cycles, skips);
    compare_count("SKIP_ONE_ASSERT pulses", 0, skips);
  endtask

  task automatic early_sync;
    int skips;
    sync_window(period_cycles - slew_d, skips);
    compare_count("SKIP_ONE_ASSERT pulses", slew_d, skips);
  endtask

  task automatic late_sync;
    int skips;
    sync_window(period_cycles + slew_d, skips);
    compare_count("SKIP_ONE_ASSERT pulses", 0, skips);
  endtask

  task automatic set_without_sync;
    logic [63:0] t_old;
    logic [63:0] t_new;
    draw_time(t_old);
    set_time(t_old);
    check_counting(200);
    draw_time(t_new);
    set_time(t_new);
    check_counting(100);
    raise_sync;
    ref_time = aligned_ticks(t_new);
    compare_time("SYS_TIME", ref_time, SYS_TIME);
    check_counting(100);
    wait_for_slot(period_cycles);
    raise_sync;
    ref_time = ref_time + 64'(period_cycles);
    compare_time("SYS_TIME", ref_time, SYS_TIME);  // a reload would have gone back to t_new
    check_counting(100);
  endtask

  initial begin
    reset = 1'b1;
    SET = 1'b0;
    ECAT_SYNC = 1'b0;
    ECAT_SYNC_TIME = '0;
    lfsr_state = 32'hbcca_e510;
    repeat (16) @(negedge CLK);
    reset = 1'b0;
    count_after_reset;
    load_random_times;
    nominal_period;
    early_sync;
    late_sync;
    set_without_sync;
    $display("Finished with no errors");
    $finish;
  end

  // the bound checker raises this flag on any failed assertion
  initial begin
    wait (sys_time_sync_i.sys_time_sync_assert_i.assert_failed === 1'b1);
    fail_run("an assertion bound onto the DUT failed");
  end

  initial begin
    #(watchdog_ns);
    fail_run("timeout, the tests did not finish within the expected run time");
  end

endmodule

`default_nettype wire

/* test/sys_time_sync_assert.sv */
// checks are off during reset, SYS_TIME may step back only in the cycle after a load
`timescale 1ns/1ps
`default_nettype none

module sys_time_sync_assert (
  input  var logic                              CLK,
  input  var logic                              reset,
  input  var logic                              SYNC,
  input  var logic                              SKIP_ONE_ASSERT,
  input  var logic [sync_time_pkg::time_w-1:0]  SYS_TIME,
  input  var logic                              load
);

  logic sync_fail = 1'b0;
  logic skip_fail = 1'b0;
  logic time_fail = 1'b0;
  logic assert_failed;

  assign assert_failed = sync_fail | skip_fail | time_fail;

  sync_single_cycle: assert property (@(posedge CLK) disable iff (reset) SYNC |=> !SYNC)
    else begin
      sync_fail = 1'b1;
      $error("SYNC stayed high for two cycles");
    end

  // slewing never overlaps the sync cycle itself
  skip_not_on_sync: assert property (@(posedge CLK) disable iff (reset)
    !(SKIP_ONE_ASSERT && SYNC))
    else begin
      skip_fail = 1'b1;
      $error("SKIP_ONE_ASSERT high together with SYNC");
    end

  time_monotonic: assert property (@(posedge CLK) disable iff (reset)
    !$past(load) |-> (SYS_TIME >= $past(SYS_TIME)))
    else begin
      time_fail = 1'b1;
      $error("SYS_TIME went backwards without a load");
    end

endmodule

bind sys_time_sync sys_time_sync_assert sys_time_sync_assert_i (
  .CLK             (CLK),
  .reset           (reset),
  .SYNC            (SYNC),
  .SKIP_ONE_ASSERT (SKIP_ONE_ASSERT),
  .SYS_TIME        (SYS_TIME),
  .load            (load)
);

`default_nettype wire

/* verilog/sys_time_sync.sv */
// plain strobes with no handshake, SET must come at least 70 cycles before the sync edge it targets
`timescale 1ns/1ps
`default_nettype none

module sys_time_sync (
  input  var logic                              CLK,
  input  var logic                              reset,
  input  var logic [sync_time_pkg::time_w-1:0]  ECAT_SYNC_TIME,
  input  var logic                              SET,
  input  var logic                              ECAT_SYNC,
  output logic [sync_time_pkg::time_w-1:0]      SYS_TIME,
  output logic                                  SYNC,
  output logic                                  SKIP_ONE_ASSERT
);

  logic                              sync_pulse;
  logic                              load;
  logic [sync_time_pkg::time_w-1:0]  aligned_time;
  logic [sync_time_pkg::time_w-1:0]  next_sync_time;

  assign SYNC = sync_pulse;

  sync_time_aligner sync_time_aligner_i (
    .CLK            (CLK),
    .reset          (reset),
    .ecat_sync_time (ECAT_SYNC_TIME),
    .set            (SET),
    .sync_pulse     (sync_pulse),
    .aligned_time   (aligned_time),
    .load           (load)
  );

  // predictor also owns the sync synchronizer
  next_sync_predictor next_sync_predictor_i (
    .CLK            (CLK),
    .reset          (reset),
    .ecat_sync      (ECAT_SYNC),
    .load           (load),
    .aligned_time   (aligned_time),
    .sync_pulse     (sync_pulse),
    .next_sync_time (next_sync_time)
  );

  sys_time_tracker sys_time_tracker_i (
    .CLK             (CLK),
    .reset           (reset),
    .sync_pulse      (sync_pulse),
    .load            (load),
    .aligned_time    (aligned_time),
    .next_sync_time  (next_sync_time),
    .sys_time        (SYS_TIME),
    .skip_one_assert (SKIP_ONE_ASSERT)
  );

endmodule

`default_nettype wire

/* verilog/sys_time_tracker.sv */
// every sync period is corrected alone, slew is one tick per cycle with no drift filter
`timescale 1ns/1ps
`default_nettype none

module sys_time_tracker (
  input  var logic                              CLK,
  input  var logic                              reset,
  input  var logic                              sync_pulse,
  input  var logic                              load,
  input  var logic [sync_time_pkg::time_w-1:0]  aligned_time,
  input  var logic [sync_time_pkg::time_w-1:0]  next_sync_time,
  output logic [sync_time_pkg::time_w-1:0]      sys_time,
  output logic                                  skip_one_assert
);

  logic [sync_time_pkg::wait_w-1:0]         wait_cnt;
  logic signed [sync_time_pkg::diff_w-1:0]  err_q;  // positive when sys_time lags
  logic signed [sync_time_pkg::diff_w-1:0]  a_diff;
  logic signed [sync_time_pkg::diff_w-1:0]  b_diff;
  logic signed [sync_time_pkg::diff_w-1:0]  s_diff;

  // operands of the prediction minus the time right after the sync edge
  always_ff @(posedge CLK) begin
    if (sync_pulse) begin
      a_diff <= {1'b0, next_sync_time};
      b_diff <= {1'b0, sys_time + 64'd1};
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      sys_time        <= '0;
      err_q           <= '0;
      wait_cnt        <= sync_time_pkg::wait_w'(sync_time_pkg::addsub_latency + 1);
      skip_one_assert <= 1'b0;
    end else begin
      skip_one_assert <= 1'b0;
      if (load) begin
        sys_time <= aligned_time;
        err_q    <= '0;
        wait_cnt <= sync_time_pkg::wait_w'(sync_time_pkg::addsub_latency + 1);
      end else if (sync_pulse) begin
        sys_time <= sys_time + 64'd1;
        wait_cnt <= '0;  // also restarts a measurement still in flight
      end else if (wait_cnt == sync_time_pkg::addsub_latency + 1) begin
        if (err_q == '0) begin
          sys_time <= sys_time + 64'd1;
        end else if (err_q[sync_time_pkg::diff_w-1]) begin
          err_q <= err_q + 1'b1;  // ahead of the prediction, stand still
        end else begin
          sys_time        <= sys_time + 64'd2;
          skip_one_assert <= 1'b1;
          err_q           <= err_q - 1'b1;
        end
      end else begin
        sys_time <= sys_time + 64'd1;
        wait_cnt <= wait_cnt + 1'b1;
        if (wait_cnt == sync_time_pkg::addsub_latency) begin
          err_q <= s_diff;
        end
      end
    end
  end

  addsub_pipe addsub_diff_i (
    .CLK   (CLK),
    .reset (reset),
    .a     (a_diff),
    .b     (b_diff),
    .op    (sync_ctrl_pkg::op_sub),
    .s     (s_diff)
  );

endmodule

`default_nettype wire

/* verilog/next_sync_predictor.sv */
// ecat_sync is asynchronous and must stay high for at least three cycles to be seen
`timescale 1ns/1ps
`default_nettype none

module next_sync_predictor (
  input  var logic                              CLK,
  input  var logic                              reset,
  input  var logic                              ecat_sync,
  input  var logic                              load,
  input  var logic [sync_time_pkg::time_w-1:0]  aligned_time,
  output logic                                  sync_pulse,
  output logic [sync_time_pkg::time_w-1:0]      next_sync_time
);

  logic [2:0]                                     sync_tri;
  logic [$bits(sync_time_pkg::sync_base_cnt)-1:0] tick_cnt;
  logic                                           wrap;
  logic [sync_time_pkg::wait_w-1:0]               wait_cnt;
  logic signed [sync_time_pkg::diff_w-1:0]        a_next;
  logic signed [sync_time_pkg::diff_w-1:0]        s_next;

  assign sync_pulse = (sync_tri == 3'b011);  // old low, two new highs
  assign wrap = !sync_pulse && (tick_cnt == sync_time_pkg::sync_base_cnt - 1'b1);

  always_ff @(posedge CLK) begin
    if (reset) begin
      sync_tri <= '0;
      tick_cnt <= '0;
    end else begin
      sync_tri <= {sync_tri[1:0], ecat_sync};
      if (sync_pulse) begin
        tick_cnt <= sync_time_pkg::sync_base_cnt >> 1;  // wrap lands half a period after sync
      end else if (wrap) begin
        tick_cnt <= '0;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    a_next <= wrap ? {1'b0, next_sync_time} : a_next;
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      wait_cnt       <= sync_time_pkg::wait_w'(sync_time_pkg::addsub_latency + 1);
      next_sync_time <= '0;
    end else if (load) begin
      wait_cnt       <= sync_time_pkg::wait_w'(sync_time_pkg::addsub_latency + 1);
      next_sync_time <= aligned_time;  // a pending sum is stale now
    end else if (wrap) begin
      wait_cnt <= '0;
    end else if (wait_cnt == sync_time_pkg::addsub_latency) begin
      wait_cnt       <= wait_cnt + 1'b1;
      next_sync_time <= s_next[sync_time_pkg::time_w-1:0];
    end else if (wait_cnt < sync_time_pkg::addsub_latency) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  addsub_pipe addsub_next_i (
    .CLK   (CLK),
    .reset (reset),
    .a     (a_next),
    .b     (sync_time_pkg::diff_w'(sync_time_pkg::sync_base_cnt)),
    .op    (sync_ctrl_pkg::op_add),
    .s     (s_next)
  );

endmodule

`default_nettype wire

/* verilog/sync_time_aligner.sv */
// SET must lead the target sync edge by at least 70 cycles, the remainder of the division is dropped
`timescale 1ns/1ps
`default_nettype none

module sync_time_aligner (
  input  var logic                              CLK,
  input  var logic                              reset,
  input  var logic [sync_time_pkg::time_w-1:0]  ecat_sync_time,
  input  var logic                              set,
  input  var logic                              sync_pulse,
  output logic [sync_time_pkg::time_w-1:0]      aligned_time,
  output logic                                  load
);

  sync_ctrl_pkg::align_state_e state_q;

  logic [$clog2(sync_time_pkg::time_w)-1:0]      step_q;
  logic [sync_time_pkg::time_w-1:0]              quo_q;  // dividend shifts out, quotient in
  logic [$bits(sync_time_pkg::sync_base_ns)-1:0] rem_q;
  logic [$bits(sync_time_pkg::sync_base_ns):0]   rem_shift;
  logic                                          rem_ge;

  assign rem_shift = {rem_q, quo_q[sync_time_pkg::time_w-1]};
  assign rem_ge    = rem_shift >= {1'b0, sync_time_pkg::sync_base_ns};

  // only place where armed and sync meet
  assign load = (state_q == sync_ctrl_pkg::align_armed) && sync_pulse;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state_q <= sync_ctrl_pkg::align_idle;
      step_q  <= '0;
    end else if (set) begin
      state_q <= sync_ctrl_pkg::align_divide;  // new time wins over any run in progress
      step_q  <= '0;
    end else begin
      case (state_q)
        sync_ctrl_pkg::align_divide: begin
          step_q <= step_q + 1'b1;
          if (&step_q) begin
            state_q <= sync_ctrl_pkg::align_scale;
          end
        end
        sync_ctrl_pkg::align_scale: begin
          state_q <= sync_ctrl_pkg::align_armed;
        end
        sync_ctrl_pkg::align_armed: begin
          if (sync_pulse) begin
            state_q <= sync_ctrl_pkg::align_idle;
          end
        end
        default: begin
          state_q <= sync_ctrl_pkg::align_idle;
        end
      endcase
    end
  end

  // restoring division, one quotient bit per cycle
  always_ff @(posedge CLK) begin
    if (set) begin
      quo_q <= ecat_sync_time;
      rem_q <= '0;
    end else if (state_q == sync_ctrl_pkg::align_divide) begin
      quo_q <= {quo_q[sync_time_pkg::time_w-2:0], rem_ge};
      if (rem_ge) begin
        rem_q <= rem_shift[$bits(sync_time_pkg::sync_base_ns)-1:0] - sync_time_pkg::sync_base_ns;
      end else begin
        rem_q <= rem_shift[$bits(sync_time_pkg::sync_base_ns)-1:0];
      end
    end
  end

  // whole periods to ticks, product is cut to 64 bits
  always_ff @(posedge CLK) begin
    if (state_q == sync_ctrl_pkg::align_scale) begin
      aligned_time <= quo_q * sync_time_pkg::sync_base_cnt;
    end
  end

endmodule

`default_nettype wire

/* verilog/addsub_pipe.sv */
// fixed latency of sync_time_pkg::addsub_latency cycles, no valid signal, needs latency >= 2
`timescale 1ns/1ps
`default_nettype none

module addsub_pipe (
  input  var logic                                       CLK,
  input  var logic                                       reset,
  input  var logic signed [sync_time_pkg::diff_w-1:0]    a,
  input  var logic signed [sync_time_pkg::diff_w-1:0]    b,
  input  var sync_ctrl_pkg::addsub_op_e                  op,
  output logic signed [sync_time_pkg::diff_w-1:0]        s
);

  logic signed [sync_time_pkg::diff_w-1:0] a_q;
  logic signed [sync_time_pkg::diff_w-1:0] b_q;
  sync_ctrl_pkg::addsub_op_e               op_q;

  // result stages behind the operand register
  logic signed [sync_time_pkg::diff_w-1:0] res_q [sync_time_pkg::addsub_latency-1];

  always_ff @(posedge CLK) begin
    if (reset) begin
      op_q <= sync_ctrl_pkg::op_add;
    end else begin
      op_q <= op;
    end
  end

  always_ff @(posedge CLK) begin
    a_q <= a;
    b_q <= b;
    if (op_q == sync_ctrl_pkg::op_sub) begin
      res_q[0] <= a_q - b_q;
    end else begin
      res_q[0] <= a_q + b_q;
    end
    for (int i = 1; i < sync_time_pkg::addsub_latency - 1; i++) begin
      res_q[i] <= res_q[i-1];
    end
  end

  assign s = res_q[sync_time_pkg::addsub_latency-2];  // operand stage counts as the first

endmodule

`default_nettype wire

/* verilog/sync_ctrl_pkg.sv */
// encodings only, widths are fixed by the enum base types
`default_nettype none

package sync_ctrl_pkg;

  // aligner sequence, a SET restarts it from any state
  typedef enum logic [1:0] {
    align_idle   = 2'd0,
    align_divide = 2'd1,
    align_scale  = 2'd2,
    align_armed  = 2'd3
  } align_state_e;

  typedef enum logic {
    op_add = 1'b0,
    op_sub = 1'b1  // s = a - b
  } addsub_op_e;

endpackage

`default_nettype wire

/* verilog/sync_time_pkg.sv */
// time constants assume a 20.48 MHz tick and a fixed 500 us sync period, addsub_latency >= 2
`default_nettype none

package sync_time_pkg;

  // every time value, in ns or in ticks
  localparam int time_w = 64;

  localparam int diff_w = time_w + 1;  // signed difference of two times

  // sync period in ns
  localparam logic [31:0] sync_base_ns = 32'd500000;

  // the same period in 20.48 MHz ticks
  localparam logic [17:0] sync_base_cnt = 18'd10240;

  // cycles from operands at addsub_pipe inputs to the result at s
  localparam int addsub_latency = 6;

  // wait counters run 0 .. addsub_latency+1 and rest at the top value
  localparam int wait_w = $clog2(addsub_latency + 2);

endpackage

`default_nettype wire
